//--- sim.f
+incdir+verification
source/saturn_isa_pkg.sv
source/mem_bus_pkg.sv
source/opcode_size_decoder.sv
source/prefetch_queue.sv
source/field_read_assembler.sv
source/bus_sequencer.sv
source/saturn_bus_ctrl.sv
verification/tb_saturn_bus_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_saturn_bus_ctrl \
    -o sim_saturn > build.log 2>&1 \
    && ./obj_dir/sim_saturn > sim.log 2>&1 \
    || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "TEST FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "no verdict found in sim.log"; exit 1; }
echo "simulation passed"

//--- verification/tb_saturn_ref.svh
`ifndef TB_SATURN_REF_SVH
`define TB_SATURN_REF_SVH

// opcode length straight from the stated opcode rules
function automatic op_len_t ref_length(input bus_addr_t addr);
    nibble_t n0;
    nibble_t n1;
    nibble_t n4;
    n0 = mem_nibs[mem_index(addr, 0)];
    n1 = mem_nibs[mem_index(addr, 1)];
    n4 = mem_nibs[mem_index(addr, 4)];
    case (n0)
        4'h3:                   return op_len_t'(3 + int'(n1));    // LC, n1 + 1 digits
        4'h8:                   return op_len_t'(6 + int'(n4));    // LA 8082n
        4'h4, 4'h5, 4'hA, 4'hB: return 5'd3;
        4'h6, 4'h7:             return 5'd4;
        4'h9:                   return 5'd5;
        default:                return 5'd2;                       // 2, C to F
    endcase
endfunction

function automatic opcode_t expected_opcode(input bus_addr_t addr);
    opcode_t r;
    r = '0;
    for (int i = 0; i < int'(ref_length(addr)); i++)
        r[4*i +: 4] = mem_nibs[mem_index(addr, i)];
    return r;
endfunction

// memory nibbles land at right..left, zero elsewhere
function automatic field_data_t expected_field(input bus_addr_t addr, input field_t left,
                                               input field_t right);
    field_data_t r;
    r = '0;
    for (int i = 0; i <= int'(left) - int'(right); i++)
        r[4*(int'(right) + i) +: 4] = mem_nibs[mem_index(addr, i)];
    return r;
endfunction

task automatic check_len(input string name, input op_len_t got, input op_len_t exp);
    check_count++;
    if (got !== exp)
    begin
        error_count++;
        $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
endtask

task automatic check_addr(input string name, input bus_addr_t got, input bus_addr_t exp);
    check_count++;
    if (got !== exp)
    begin
        error_count++;
        $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_opcode(input string name, input opcode_t got, input opcode_t exp);
    check_count++;
    if (got !== exp)
    begin
        error_count++;
        $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_field(input string name, input field_data_t got, input field_data_t exp);
    check_count++;
    if (got !== exp)
    begin
        error_count++;
        $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

`endif

//--- verification/tb_saturn_bus_ctrl.sv
`timescale 1ns/1ps

module tb_saturn_bus_ctrl;
    import saturn_isa_pkg::*;
    import mem_bus_pkg::*;

    localparam int        MEM_NIBS       = 4096;
    localparam bus_addr_t PROG_BASE      = 20'h00103;    // unaligned start right after reset
    localparam bus_addr_t PROG_LIMIT     = 20'h00DAC;
    localparam int        CHAIN_LEN      = 30;
    localparam int        FLUSH_FETCHES  = 5;
    localparam int        FIELD_READS    = 24;
    localparam int        MIXED_ROUNDS   = 6;
    localparam int        NUM_OPS        = 1 + CHAIN_LEN + 4*(FLUSH_FETCHES + 3) + FIELD_READS
                                           + 2*MIXED_ROUNDS + 1;
    localparam int        TIMEOUT_CYCLES = NUM_OPS*60 + 200;

    logic        clk_in;
    logic        arst_n_i;
    bus_word_t   bus_data_i;
    bus_addr_t   bus_addr_o;
    logic        bus_rd_n_o;
    bus_addr_t   ibus_addr_i;
    logic        ibus_flush_i;
    logic        ibus_fetch_i;
    opcode_t     ibus_opcode_o;
    op_len_t     ibus_length_o;
    bus_addr_t   ibus_opcode_addr_o;
    logic        ibus_ready_o;
    bus_addr_t   data_addr_i;
    field_t      data_field_left_i;
    field_t      data_field_right_i;
    logic        data_read_i;
    field_data_t data_o;
    logic        data_read_ready_o;

    nibble_t     mem_nibs [0:MEM_NIBS-1];
    nibble_t     fixed_firsts [12] = '{4'h2, 4'hC, 4'hD, 4'hE, 4'hF, 4'h4, 4'h5, 4'hA, 4'hB,
                                       4'h6, 4'h7, 4'h9};
    bus_addr_t   op_starts [$];
    bus_addr_t   ibus_exp_q [$];       // addresses of opcodes still to be presented
    field_data_t field_exp_q [$];
    bus_addr_t   cur_addr;
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;

    function automatic logic [11:0] mem_index(input bus_addr_t addr, input int i);
        bus_addr_t a;
        a = addr + bus_addr_t'(i);
        return a[11:0];
    endfunction

    `include "tb_saturn_ref.svh"

    // word read returns four nibbles, lowest address in bits 3:0
    // data only while the read strobe is low
    assign bus_data_i = bus_rd_n_o ? '0 :
                        {mem_nibs[{bus_addr_o[11:2], 2'd3}], mem_nibs[{bus_addr_o[11:2], 2'd2}],
                         mem_nibs[{bus_addr_o[11:2], 2'd1}], mem_nibs[{bus_addr_o[11:2], 2'd0}]};

    saturn_bus_ctrl #(
        .QUEUE_NIBS (24)
    ) UUT (
        .clk_in             (clk_in),
        .arst_n_i           (arst_n_i),
        .bus_data_i         (bus_data_i),
        .bus_addr_o         (bus_addr_o),
        .bus_rd_n_o         (bus_rd_n_o),
        .ibus_addr_i        (ibus_addr_i),
        .ibus_flush_i       (ibus_flush_i),
        .ibus_fetch_i       (ibus_fetch_i),
        .ibus_opcode_o      (ibus_opcode_o),
        .ibus_length_o      (ibus_length_o),
        .ibus_opcode_addr_o (ibus_opcode_addr_o),
        .ibus_ready_o       (ibus_ready_o),
        .data_addr_i        (data_addr_i),
        .data_field_left_i  (data_field_left_i),
        .data_field_right_i (data_field_right_i),
        .data_read_i        (data_read_i),
        .data_o             (data_o),
        .data_read_ready_o  (data_read_ready_o)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    // random program of stated opcodes, every ninth one a 21 nibble LA
    task automatic build_program;
        bus_addr_t a;
        op_group_e grp;
        int        count;
        int        hdr;
        a = PROG_BASE;
        count = 0;
        while (a < PROG_LIMIT)
        begin
            op_starts.push_back(a);
            case ($urandom % 4)
                0:       grp = GRP_LC;
                1:       grp = GRP_8;
                default: grp = GRP_FIXED;
            endcase
            if (count % 9 == 8)
                grp = GRP_8;
            case (grp)
                GRP_LC:
                begin
                    mem_nibs[mem_index(a, 0)] = 4'h3;
                    mem_nibs[mem_index(a, 1)] = nibble_t'($urandom % 16);
                    hdr = 2;
                end
                GRP_8:
                begin
                    mem_nibs[mem_index(a, 0)] = 4'h8;
                    mem_nibs[mem_index(a, 1)] = 4'h0;
                    mem_nibs[mem_index(a, 2)] = 4'h8;
                    mem_nibs[mem_index(a, 3)] = 4'h2;
                    mem_nibs[mem_index(a, 4)] = (count % 9 == 8) ? 4'hF : nibble_t'($urandom % 16);
                    hdr = 5;
                end
                default:
                begin
                    mem_nibs[mem_index(a, 0)] = fixed_firsts[$urandom % 12];
                    hdr = 1;
                end
            endcase
            for (int i = hdr; i < int'(ref_length(a)); i++)
                mem_nibs[mem_index(a, i)] = nibble_t'($urandom % 16);
            a = a + bus_addr_t'(ref_length(a));
            count++;
        end
    endtask

    function automatic bus_addr_t pick_start(input bit long_la, input word_offset_t off);
        int idx;
        idx = int'($urandom % 32'(op_starts.size() - 80));
        for (int i = idx; i < op_starts.size(); i++)
        begin
            if (op_starts[i][1:0] == off && (!long_la || ref_length(op_starts[i]) == 5'd21))
                return op_starts[i];
        end
        return op_starts[idx];
    endfunction

    task automatic wait_ibus_ready;
        do @(negedge clk_in); while (ibus_ready_o !== 1'b1);
    endtask

    task automatic wait_data_ready;
        do @(negedge clk_in); while (data_read_ready_o !== 1'b1);
    endtask

    task automatic fetch_next;
        cur_addr = cur_addr + bus_addr_t'(ref_length(cur_addr));
        ibus_exp_q.push_back(cur_addr);
        @(posedge clk_in);
        ibus_fetch_i <= 1'b1;
        wait_ibus_ready();
        @(posedge clk_in);
        ibus_fetch_i <= 1'b0;
    endtask

    task automatic flush_to(input bus_addr_t addr);
        cur_addr = addr;
        ibus_exp_q.push_back(addr);
        @(posedge clk_in);
        ibus_addr_i  <= addr;    // stays put until the next flush
        ibus_flush_i <= 1'b1;
        @(posedge clk_in);
        ibus_flush_i <= 1'b0;
        wait_ibus_ready();
        @(posedge clk_in);
    endtask

    task automatic field_read(input bus_addr_t addr, input field_t left, input field_t right);
        field_exp_q.push_back(expected_field(addr, left, right));
        @(posedge clk_in);
        data_addr_i        <= addr;
        data_field_left_i  <= left;
        data_field_right_i <= right;
        data_read_i        <= 1'b1;
        wait_data_ready();
        @(posedge clk_in);
        data_read_i <= 1'b0;
    endtask

    task automatic random_field_read;
        int r;
        int l;
        r = int'($urandom % 16);
        l = r + int'($urandom % 32'(16 - r));
        field_read(bus_addr_t'($urandom % (MEM_NIBS - 24)), field_t'(l), field_t'(r));
    endtask

    always @(negedge clk_in)
    begin : compare_responses
        bus_addr_t exp_addr;
        if (arst_n_i === 1'b1 && ibus_ready_o === 1'b1)
        begin
            if (ibus_exp_q.size() == 0)
            begin
                error_count++;
                $display("ERROR at %0t: opcode presented with no request outstanding", $time);
            end
            else
            begin
                exp_addr = ibus_exp_q.pop_front();
                check_addr("ibus_opcode_addr_o", ibus_opcode_addr_o, exp_addr);
                check_len("ibus_length_o", ibus_length_o, ref_length(exp_addr));
                check_opcode("ibus_opcode_o", ibus_opcode_o, expected_opcode(exp_addr));
            end
        end
        if (arst_n_i === 1'b1 && data_read_ready_o === 1'b1)
        begin
            if (field_exp_q.size() == 0)
            begin
                error_count++;
                $display("ERROR at %0t: data ready with no read outstanding", $time);
            end
            else
                check_field("data_o", data_o, field_exp_q.pop_front());
        end
    end

    initial
    begin
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk_in);
            cycle_count++;
        end
        $display("ERROR at %0t: timeout after %0d cycles, checks %0d, errors %0d", $time,
                 cycle_count, check_count, error_count);
        $display("TEST FAIL");
        $finish;
    end

    initial
    begin
        int seed_ret;
        seed_ret           = $urandom(32'hb63b);
        arst_n_i           = 1'b0;
        ibus_addr_i        = PROG_BASE;
        ibus_flush_i       = 1'b0;
        ibus_fetch_i       = 1'b0;
        data_addr_i        = '0;
        data_field_left_i  = '0;
        data_field_right_i = '0;
        data_read_i        = 1'b0;
        for (int a = 0; a < MEM_NIBS; a++)
            mem_nibs[a] = nibble_t'(a ^ (a >> 4) ^ (a >> 8));
        build_program();
        cur_addr = PROG_BASE;
        ibus_exp_q.push_back(PROG_BASE);    // delivered without a fetch
        repeat (9) @(posedge clk_in);
        @(negedge clk_in);
        if (bus_rd_n_o !== 1'b1 || ibus_ready_o !== 1'b0 || data_read_ready_o !== 1'b0)
        begin
            error_count++;
            $display("ERROR at %0t: read strobe or a ready output active in reset", $time);
        end
        @(posedge clk_in);
        arst_n_i <= 1'b1;
        wait_ibus_ready();
        repeat (20) @(posedge clk_in);      // quiet window, no second opcode
        repeat (CHAIN_LEN) fetch_next();
        for (int k = 0; k < 4; k++)
        begin
            flush_to(pick_start(1'b0, word_offset_t'(k)));
            repeat (FLUSH_FETCHES) fetch_next();
            flush_to(pick_start(1'b1, word_offset_t'(k)));
            fetch_next();
        end
        field_read(20'h00200, 4'd15, 4'd0);
        field_read(20'h00333, 4'd7, 4'd7);
        repeat (FIELD_READS - 2) random_field_read();
        for (int k = 0; k < MIXED_ROUNDS; k++)
        begin
            fetch_next();
            random_field_read();
        end
        fetch_next();
        repeat (5) @(posedge clk_in);
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- source/saturn_bus_ctrl.sv
`timescale 1ns/1ps

module saturn_bus_ctrl #(
    parameter int QUEUE_NIBS = 24       // at least MAX_OPCODE_NIBS + 3
) (
    input  logic                          clk_in,
    input  logic                          arst_n_i,
    input  mem_bus_pkg::bus_word_t        bus_data_i,
    output mem_bus_pkg::bus_addr_t        bus_addr_o,
    output logic                          bus_rd_n_o,
    input  mem_bus_pkg::bus_addr_t        ibus_addr_i,      // held while a flush is served
    input  logic                          ibus_flush_i,
    input  logic                          ibus_fetch_i,
    output saturn_isa_pkg::opcode_t       ibus_opcode_o,
    output saturn_isa_pkg::op_len_t       ibus_length_o,
    output mem_bus_pkg::bus_addr_t        ibus_opcode_addr_o,
    output logic                          ibus_ready_o,
    input  mem_bus_pkg::bus_addr_t        data_addr_i,
    input  saturn_isa_pkg::field_t        data_field_left_i,
    input  saturn_isa_pkg::field_t        data_field_right_i,
    input  logic                          data_read_i,
    output saturn_isa_pkg::field_data_t   data_o,
    output logic                          data_read_ready_o
);
    import mem_bus_pkg::*;

    logic      q_clear;
    bus_addr_t q_start_addr;
    logic      q_load;
    logic      q_pop;
    logic      have_opcode;
    logic      rd_start;
    logic      rd_load;
    logic      read_complete;

    bus_sequencer u_seq (
        .clk_in          (clk_in),
        .arst_n_i        (arst_n_i),
        .ibus_addr_i     (ibus_addr_i),
        .ibus_flush_i    (ibus_flush_i),
        .ibus_fetch_i    (ibus_fetch_i),
        .data_read_i     (data_read_i),
        .data_addr_i     (data_addr_i),
        .have_opcode_i   (have_opcode),
        .read_complete_i (read_complete),
        .bus_addr_o      (bus_addr_o),
        .bus_rd_n_o      (bus_rd_n_o),
        .q_clear_o       (q_clear),
        .q_start_addr_o  (q_start_addr),
        .q_load_o        (q_load),
        .q_pop_o         (q_pop),
        .rd_start_o      (rd_start),
        .rd_load_o       (rd_load)
    );

    prefetch_queue #(
        .QUEUE_NIBS (QUEUE_NIBS)
    ) u_queue (
        .clk_in        (clk_in),
        .arst_n_i      (arst_n_i),
        .clear_i       (q_clear),
        .start_addr_i  (q_start_addr),
        .load_i        (q_load),
        .word_i        (bus_data_i),
        .offset_i      (bus_addr_o[1:0]),
        .pop_i         (q_pop),
        .have_opcode_o (have_opcode),
        .opcode_o      (ibus_opcode_o),
        .length_o      (ibus_length_o),
        .opcode_addr_o (ibus_opcode_addr_o),
        .ready_o       (ibus_ready_o)
    );

    field_read_assembler u_field (
        .clk_in        (clk_in),
        .arst_n_i      (arst_n_i),
        .start_i       (rd_start),
        .field_left_i  (data_field_left_i),
        .field_right_i (data_field_right_i),
        .load_i        (rd_load),
        .word_i        (bus_data_i),
        .offset_i      (bus_addr_o[1:0]),
        .complete_o    (read_complete),
        .data_o        (data_o),
        .ready_o       (data_read_ready_o)
    );

endmodule

//--- source/bus_sequencer.sv
`timescale 1ns/1ps

module bus_sequencer (
    input  logic                      clk_in,
    input  logic                      arst_n_i,
    input  mem_bus_pkg::bus_addr_t    ibus_addr_i,
    input  logic                      ibus_flush_i,
    input  logic                      ibus_fetch_i,
    input  logic                      data_read_i,
    input  mem_bus_pkg::bus_addr_t    data_addr_i,
    input  logic                      have_opcode_i,
    input  logic                      read_complete_i,
    output mem_bus_pkg::bus_addr_t    bus_addr_o,
    output logic                      bus_rd_n_o,
    output logic                      q_clear_o,
    output mem_bus_pkg::bus_addr_t    q_start_addr_o,
    output logic                      q_load_o,
    output logic                      q_pop_o,
    output logic                      rd_start_o,
    output logic                      rd_load_o
);
    import mem_bus_pkg::*;

    seq_state_e state_q;
    seq_state_e state_d;
    bus_addr_t  fetch_addr_q;   // unaligned only for the first word after a flush
    bus_addr_t  read_addr_q;
    logic       settle_q;       // a ready pulse is out, requests wait one cycle
    logic       data_phase;

    function automatic bus_addr_t next_word(input bus_addr_t addr);
        return {addr[19:2], 2'b00} + bus_addr_t'(NIBS_PER_WORD);
    endfunction

    assign data_phase     = (state_q == ST_READ) || (state_q == ST_READ_CHECK);
    assign bus_addr_o     = data_phase ? read_addr_q : fetch_addr_q;
    assign bus_rd_n_o     = !((state_q == ST_FETCH_WORD) || (state_q == ST_READ));
    assign q_clear_o      = (state_q == ST_FLUSH);
    assign q_start_addr_o = ibus_addr_i;
    assign q_load_o       = (state_q == ST_FETCH_WORD);
    assign q_pop_o        = (state_q == ST_CHECK_SIZE) && have_opcode_i;
    assign rd_start_o     = (state_q == ST_IDLE) && !ibus_flush_i && data_read_i && !settle_q;
    assign rd_load_o      = (state_q == ST_READ);

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            ST_FLUSH:      state_d = ST_FETCH_WORD;
            ST_FETCH_WORD: state_d = ST_CHECK_SIZE;
            ST_CHECK_SIZE: state_d = have_opcode_i ? ST_IDLE : ST_FETCH_WORD;
            ST_IDLE:
            begin
                // flush wins over a data read, a data read over a fetch
                if (ibus_flush_i)
                    state_d = ST_FLUSH;
                else if (rd_start_o)
                    state_d = ST_READ;
                else if (ibus_fetch_i && !settle_q)
                    state_d = ST_CHECK_SIZE;
            end
            ST_READ:       state_d = ST_READ_CHECK;
            ST_READ_CHECK: state_d = read_complete_i ? ST_IDLE : ST_READ;
            default:       state_d = ST_FLUSH;
        endcase
    end

    always_ff @(posedge clk_in or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            state_q      <= ST_FLUSH;     // behave as flushed to ibus_addr_i
            settle_q     <= 1'b0;
            fetch_addr_q <= '0;
            read_addr_q  <= '0;
        end
        else
        begin
            state_q  <= state_d;
            settle_q <= q_pop_o || ((state_q == ST_READ_CHECK) && read_complete_i);
            if (q_clear_o)
                fetch_addr_q <= ibus_addr_i;
            else if (q_load_o)
                fetch_addr_q <= next_word(fetch_addr_q);
            if (rd_start_o)
                read_addr_q <= data_addr_i;
            else if (rd_load_o)
                read_addr_q <= next_word(read_addr_q);
        end
    end

endmodule

//--- source/field_read_assembler.sv
`timescale 1ns/1ps

module field_read_assembler (
    input  logic                          clk_in,
    input  logic                          arst_n_i,
    input  logic                          start_i,
    input  saturn_isa_pkg::field_t        field_left_i,
    input  saturn_isa_pkg::field_t        field_right_i,
    input  logic                          load_i,
    input  mem_bus_pkg::bus_word_t        word_i,
    input  mem_bus_pkg::word_offset_t     offset_i,
    output logic                          complete_o,
    output saturn_isa_pkg::field_data_t   data_o,
    output logic                          ready_o
);
    import saturn_isa_pkg::*;
    import mem_bus_pkg::*;

    localparam int FIELD_NIBS = 16;

    nibble_t [FIELD_NIBS-1:0] gather_q;     // nibbles in read order, first at index 0
    nibble_t [FIELD_NIBS-1:0] gather_d;
    op_len_t                  count_q;
    op_len_t                  need_q;       // left - right + 1
    field_t                   right_q;
    logic                     busy_q;
    field_data_t              low_mask;
    field_data_t              aligned;

    assign complete_o = busy_q && (count_q >= need_q);
    assign low_mask   = ~(field_data_t'('1) << {need_q, 2'b00});
    assign aligned    = (gather_q & low_mask) << {right_q, 2'b00};

    always_comb
    begin
        gather_d = gather_q;
        for (int i = 0; i < NIBS_PER_WORD; i++)
        begin
            if ((i >= offset_i) && ((count_q + i - offset_i) < FIELD_NIBS))
                gather_d[count_q + i - offset_i] = word_i[4*i +: 4];
        end
    end

    always_ff @(posedge clk_in or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            busy_q  <= 1'b0;
            count_q <= '0;
            ready_o <= 1'b0;
        end
        else
        begin
            ready_o <= complete_o;
            if (start_i)
            begin
                busy_q  <= 1'b1;
                count_q <= '0;
            end
            else if (complete_o)
                busy_q <= 1'b0;
            else if (load_i)
                count_q <= count_q + (op_len_t'(NIBS_PER_WORD) - {3'b000, offset_i});
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (start_i)
        begin
            right_q <= field_right_i;
            need_q  <= {1'b0, field_left_i} - {1'b0, field_right_i} + 5'd1;
        end
        if (load_i)
            gather_q <= gather_d;
        if (complete_o)
            data_o <= aligned;      // zero outside right..left
    end

endmodule

//--- source/prefetch_queue.sv
`timescale 1ns/1ps

module prefetch_queue #(
    parameter int QUEUE_NIBS = 24
) (
    input  logic                         clk_in,
    input  logic                         arst_n_i,
    input  logic                         clear_i,
    input  mem_bus_pkg::bus_addr_t       start_addr_i,
    input  logic                         load_i,
    input  mem_bus_pkg::bus_word_t       word_i,
    input  mem_bus_pkg::word_offset_t    offset_i,
    input  logic                         pop_i,
    output logic                         have_opcode_o,
    output saturn_isa_pkg::opcode_t      opcode_o,
    output saturn_isa_pkg::op_len_t      length_o,
    output mem_bus_pkg::bus_addr_t       opcode_addr_o,
    output logic                         ready_o
);
    import saturn_isa_pkg::*;
    import mem_bus_pkg::*;

    nibble_t [QUEUE_NIBS-1:0] q_nibs;       // head opcode starts at index 0
    nibble_t [QUEUE_NIBS-1:0] load_nibs;
    op_len_t                  q_count;
    op_len_t                  load_count;   // nibbles taken from the incoming word
    op_len_t                  head_len;
    bus_addr_t                head_addr;    // address of q_nibs[0]
    opcode_t                  head_opcode;

    opcode_size_decoder u_size_dec (
        .head_i         (q_nibs[DECODE_NIBS-1:0]),
        .nibble_count_i (q_count),
        .length_o       (head_len)
    );

    assign have_opcode_o = (q_count >= 5'd2) && (head_len <= q_count);
    assign load_count    = op_len_t'(NIBS_PER_WORD) - {3'b000, offset_i};

    // append the word from its offset nibble upward
    always_comb
    begin
        load_nibs = q_nibs;
        for (int i = 0; i < NIBS_PER_WORD; i++)
        begin
            if (i >= offset_i)
                load_nibs[q_count + i - offset_i] = word_i[4*i +: 4];
        end
    end

    always_comb
    begin
        head_opcode = '0;
        for (int i = 0; i < MAX_OPCODE_NIBS; i++)
        begin
            if (i < head_len)
                head_opcode[4*i +: 4] = q_nibs[i];   // nibbles past the opcode read as zero
        end
    end

    always_ff @(posedge clk_in or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            q_count <= '0;
            ready_o <= 1'b0;
        end
        else
        begin
            ready_o <= pop_i;
            if (clear_i)
                q_count <= '0;
            else if (load_i)
                q_count <= q_count + load_count;
            else if (pop_i)
                q_count <= q_count - head_len;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (clear_i)
        begin
            q_nibs    <= '0;
            head_addr <= start_addr_i;
        end
        else if (load_i)
            q_nibs <= load_nibs;
        else if (pop_i)
        begin
            q_nibs        <= q_nibs >> {head_len, 2'b00};
            head_addr     <= head_addr + {15'd0, head_len};
            opcode_o      <= head_opcode;
            length_o      <= head_len;
            opcode_addr_o <= head_addr;
        end
    end

endmodule

//--- source/opcode_size_decoder.sv
`timescale 1ns/1ps

module opcode_size_decoder (
    input  saturn_isa_pkg::nibble_t [saturn_isa_pkg::DECODE_NIBS-1:0] head_i,
    input  saturn_isa_pkg::op_len_t                                    nibble_count_i,
    output saturn_isa_pkg::op_len_t                                    length_o
);
    import saturn_isa_pkg::*;

    op_group_e group;
    nibble_t   op0;
    nibble_t   op1;
    nibble_t   op2;
    nibble_t   op3;
    nibble_t   op4;
    op_len_t   len_fixed;
    op_len_t   len_1;
    op_len_t   len_8_short;    // 8x sized from the second nibble only
    op_len_t   len_8_full;

    assign op0 = head_i[0];
    assign op1 = head_i[1];
    assign op2 = head_i[2];
    assign op3 = head_i[3];
    assign op4 = head_i[4];

    always_comb
    begin
        case (op0)
            4'h0:    group = GRP_0;
            4'h1:    group = GRP_1;
            4'h3:    group = GRP_LC;
            4'h8:    group = GRP_8;
            default: group = GRP_FIXED;
        endcase
    end

    always_comb
    begin
        case (op0)
            4'h4, 4'h5, 4'hA, 4'hB: len_fixed = 5'd3;
            4'h6, 4'h7:             len_fixed = 5'd4;     // GOTO and GOSUB
            4'h9:                   len_fixed = 5'd5;     // test with goyes
            default:                len_fixed = 5'd2;     // 2, C to F
        endcase
    end

    always_comb
    begin
        case (op1)
            4'h5, 4'h9, 4'hD: len_1 = 5'd4;
            4'hA, 4'hE:       len_1 = 5'd6;
            4'hB, 4'hF:       len_1 = 5'd7;
            default:          len_1 = 5'd3;
        endcase
    end

    always_comb
    begin
        case (op1)
            4'h2, 4'h4, 4'h5:                         len_8_short = 5'd3;
            4'h3, 4'h6, 4'h7, 4'h8, 4'h9, 4'hA, 4'hB: len_8_short = 5'd5;
            4'hC, 4'hE:                               len_8_short = 5'd6;  // GOLONG, GOSUBL
            4'hD, 4'hF:                               len_8_short = 5'd7;  // GOVLNG, GOSBVL
            default:                                  len_8_short = 5'd5;  // 80 and 81 need more
        endcase
    end

    always_comb
    begin
        len_8_full = len_8_short;
        if (op1 == 4'h0)
        begin
            case (op2)
                4'h8:
                begin
                    case (op3)
                        4'h0, 4'hF:             len_8_full = 5'd4;
                        4'h2:                   len_8_full = 5'd6 + {1'b0, op4};    // LA 8082n
                        4'h6, 4'h7, 4'hA, 4'hB: len_8_full = 5'd7;
                        default:                len_8_full = 5'd5;
                    endcase
                end
                4'hC, 4'hD, 4'hF: len_8_full = 5'd4;
                default:          len_8_full = 5'd3;
            endcase
        end
        else if (op1 == 4'h1)
        begin
            case (op2)
                4'h8, 4'hA: len_8_full = 5'd6;
                4'h9:       len_8_full = 5'd5;
                4'hB:       len_8_full = 5'd4;
                default:    len_8_full = 5'd3;
            endcase
        end
    end

    always_comb
    begin
        length_o = 5'd5;    // undecided, makes the queue wait for more nibbles
        if (nibble_count_i >= 5'd2)
        begin
            case (group)
                GRP_0:   length_o = (op1 == 4'hE) ? 5'd4 : 5'd2;
                GRP_1:   length_o = len_1;
                GRP_LC:  length_o = 5'd3 + {1'b0, op1};
                GRP_8:   length_o = (nibble_count_i >= 5'd4) ? len_8_full : len_8_short;
                default: length_o = len_fixed;
            endcase
        end
    end

endmodule

//--- source/mem_bus_pkg.sv
package mem_bus_pkg;

    localparam int NIBS_PER_WORD = 4;

    // nibble address, the word address is bits 19:2
    typedef logic [19:0] bus_addr_t;

    typedef logic [15:0] bus_word_t;

    typedef logic [1:0] word_offset_t;     // nibble position inside a word

    typedef enum logic [2:0]
    {
        ST_FLUSH,           // restart prefetch at the instruction address
        ST_FETCH_WORD,      // read strobe active for one prefetch word
        ST_CHECK_SIZE,      // hand out an opcode or read more
        ST_IDLE,            // wait for a CPU request
        ST_READ,            // read strobe active for one data word
        ST_READ_CHECK       // field complete or read the next word
    } seq_state_e;

endpackage

//--- source/saturn_isa_pkg.sv
package saturn_isa_pkg;

    localparam int MAX_OPCODE_NIBS = 21;    // LA with a full 16 digit constant
    localparam int DECODE_NIBS     = 5;     // enough leading nibbles to size any opcode

    typedef logic [3:0] nibble_t;

    // length of an opcode in nibbles
    typedef logic [4:0] op_len_t;

    typedef logic [4*MAX_OPCODE_NIBS-1:0] opcode_t;    // first fetched nibble in bits 3:0

    // field boundary as a nibble index inside a 64 bit register
    typedef logic [3:0] field_t;

    typedef logic [63:0] field_data_t;

    // leading nibble classes that pick the length rule
    typedef enum logic [3:0]
    {
        GRP_0     = 4'h0,   // 0x and 0Exy
        GRP_1     = 4'h1,   // register moves and memory transfers
        GRP_LC    = 4'h3,   // load constant, second nibble gives the digit count
        GRP_8     = 4'h8,   // extended group, may need up to five nibbles
        GRP_FIXED = 4'hF    // length known from the first nibble alone
    } op_group_e;

endpackage
